//--- hw/dp_pkg.sv
// Data-processing pipeline definitions
package dp_pkg;

  localparam int WORD_W   = 32;
  localparam int NUM_REGS = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0]        reg_idx_t;

  // ARM data-processing opcode order
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } alu_op_t;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic       valid;
    cond_t      cond;
    alu_op_t    op;
    logic       set_flags;
    logic       imm_form;
    reg_idx_t   rd;
    word_t      operand_a;    // Rn value after forwarding
    word_t      rm_value;     // Rm value after forwarding
    logic [11:0] shift_field;
  } ex_ctrl_t;

  // Value execute commits at the next edge
  typedef struct packed {
    logic     write;
    reg_idx_t rd;
    word_t    data;
  } fwd_t;

  typedef struct packed {
    logic     valid;
    logic     executed;
    logic     write;
    reg_idx_t rd;
    word_t    data;
    flags_t   flags;
  } result_t;

  // Compare and test opcodes only touch the flags
  function automatic logic writes_rd(alu_op_t op);
    return !(op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});
  endfunction

endpackage

//--- hw/reg_file.sv
// Register file
`timescale 1ns/1ps

module reg_file import dp_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rn_idx,
  input  reg_idx_t rm_idx,
  input  reg_idx_t wr_idx,
  input  logic     wr_en,
  input  word_t    wr_data,
  output word_t    rn_data,
  output word_t    rm_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;                  // Single write port
    end
  end

  // Old value is visible during the write cycle
  assign rn_data = regs[rn_idx];
  assign rm_data = regs[rm_idx];

  a_wr_data_known: assert property (
    @(posedge clk) disable iff (reset) wr_en |-> !$isunknown(wr_data)
  ) else $error("reg_file write of unknown data to r%0d", wr_idx);

endmodule

//--- hw/operand_shifter.sv
// Second operand shifter
`timescale 1ns/1ps

module operand_shifter import dp_pkg::*; (
  input  logic        imm_form,
  input  logic [11:0] shift_field,
  input  word_t       rm_value,
  output word_t       operand_b
);

  logic [4:0]          rot_amt;
  logic [4:0]          shift_amt;
  logic [1:0]          shift_type;
  word_t               imm_word;
  logic [2*WORD_W-1:0] imm_rot;
  logic [2*WORD_W-1:0] rm_rot;

  assign rot_amt    = {shift_field[11:8], 1'b0};    // Twice the rotate field
  assign shift_amt  = shift_field[11:7];
  assign shift_type = shift_field[6:5];
  assign imm_word   = {{(WORD_W-8){1'b0}}, shift_field[7:0]};

  // Doubled word turns a right shift into a rotate
  assign imm_rot = {imm_word, imm_word} >> rot_amt;
  assign rm_rot  = {rm_value, rm_value} >> shift_amt;

  always_comb begin
    if (imm_form) begin
      operand_b = imm_rot[WORD_W-1:0];
    end else begin
      case (shift_type)
        2'b00:   operand_b = rm_value << shift_amt;             // LSL
        2'b01:   operand_b = rm_value >> shift_amt;             // LSR
        2'b10:   operand_b = word_t'($signed(rm_value) >>> shift_amt);  // ASR
        default: operand_b = rm_rot[WORD_W-1:0];                // ROR
      endcase
    end
  end

  // A zero amount leaves rm_value unchanged for every type

endmodule

//--- hw/alu.sv
// Data-processing ALU
`timescale 1ns/1ps

module alu import dp_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  input  logic    carry_in,
  input  flags_t  flags_in,
  output word_t   data,
  output flags_t  flags_out
);

  word_t         add_x;
  word_t         add_y;
  logic          add_cin;
  logic          arith;
  logic [WORD_W:0] sum;

  // One adder serves every arithmetic opcode
  always_comb begin
    arith   = 1'b1;
    add_x   = a;
    add_y   = b;
    add_cin = 1'b0;
    case (op)
      OP_SUB, OP_CMP: begin
        add_y   = ~b;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = 1'b1;
      end
      OP_ADC:         add_cin = carry_in;
      OP_SBC: begin
        add_y   = ~b;
        add_cin = carry_in;                     // Borrow is not carry
      end
      OP_RSC: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = carry_in;
      end
      OP_ADD, OP_CMN: add_cin = 1'b0;
      default:        arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{WORD_W{1'b0}}, add_cin};

  always_comb begin
    case (op)
      OP_AND, OP_TST: data = a & b;
      OP_EOR, OP_TEQ: data = a ^ b;
      OP_ORR:         data = a | b;
      OP_MOV:         data = b;
      OP_BIC:         data = a & ~b;
      OP_MVN:         data = ~b;
      default:        data = sum[WORD_W-1:0];
    endcase
  end

  assign flags_out.n = data[WORD_W-1];
  assign flags_out.z = (data == '0);
  assign flags_out.c = arith ? sum[WORD_W] : flags_in.c;    // Logical ops keep C
  // Overflow when same-sign addends give a different-sign sum
  assign flags_out.v = arith ? ((add_x[WORD_W-1] == add_y[WORD_W-1]) &&
                                (sum[WORD_W-1] != add_x[WORD_W-1]))
                             : flags_in.v;

endmodule

//--- hw/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ps

module decode_stage import dp_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  word_t    instr,
  output reg_idx_t rn_idx,
  output reg_idx_t rm_idx,
  input  word_t    rn_data,
  input  word_t    rm_data,
  input  fwd_t     fwd,
  output ex_ctrl_t ex_ctrl
);

  logic     id_valid;
  word_t    id_instr;
  ex_ctrl_t ex_next;

  // Instruction register, captured at the accepting edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_instr <= '0;
    end else begin
      id_valid <= instr_valid;
      id_instr <= instr;
    end
  end

  assign rn_idx = id_instr[19:16];
  assign rm_idx = id_instr[3:0];

  always_comb begin
    ex_next.valid       = id_valid;
    ex_next.cond        = cond_t'(id_instr[31:28]);
    ex_next.op          = alu_op_t'(id_instr[24:21]);
    ex_next.set_flags   = id_instr[20];
    ex_next.imm_form    = id_instr[25];
    ex_next.rd          = id_instr[15:12];
    ex_next.shift_field = id_instr[11:0];
    // Older results are already in the register file
    ex_next.operand_a   = (fwd.write && fwd.rd == rn_idx) ? fwd.data : rn_data;
    ex_next.rm_value    = (fwd.write && fwd.rd == rm_idx) ? fwd.data : rm_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_ctrl <= '0;
    end else begin
      ex_ctrl <= ex_next;
    end
  end

  // Register-specified shift amounts are not decoded
  a_no_reg_shift: assert property (
    @(posedge clk) disable iff (reset) (instr_valid && !instr[25]) |-> !instr[4]
  ) else $error("register-form instruction with bit 4 set: %h", instr);

endmodule

//--- hw/execute_stage.sv
// Execute stage with status register
`timescale 1ns/1ps

module execute_stage import dp_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  ex_ctrl_t ex_ctrl,
  output fwd_t     fwd,
  output result_t  result,
  output flags_t   flags
);

  word_t  operand_b;
  word_t  alu_data;
  flags_t alu_flags;
  flags_t next_flags;
  logic   executed;

  function automatic logic cond_pass(cond_t cond, flags_t f);
    case (cond)
      COND_EQ: return f.z;
      COND_NE: return !f.z;
      COND_CS: return f.c;
      COND_CC: return !f.c;
      COND_MI: return f.n;
      COND_PL: return !f.n;
      COND_VS: return f.v;
      COND_VC: return !f.v;
      COND_HI: return f.c && !f.z;
      COND_LS: return !f.c || f.z;
      COND_GE: return f.n == f.v;
      COND_LT: return f.n != f.v;
      COND_GT: return !f.z && (f.n == f.v);
      COND_LE: return f.z || (f.n != f.v);
      COND_AL: return 1'b1;
      default: return 1'b0;                     // NV never executes
    endcase
  endfunction

  operand_shifter u_shifter (
    .imm_form    (ex_ctrl.imm_form),
    .shift_field (ex_ctrl.shift_field),
    .rm_value    (ex_ctrl.rm_value),
    .operand_b   (operand_b)
  );

  alu u_alu (
    .op        (ex_ctrl.op),
    .a         (ex_ctrl.operand_a),
    .b         (operand_b),
    .carry_in  (flags.c),
    .flags_in  (flags),
    .data      (alu_data),
    .flags_out (alu_flags)
  );

  assign executed   = ex_ctrl.valid && cond_pass(ex_ctrl.cond, flags);
  assign next_flags = (executed && ex_ctrl.set_flags) ? alu_flags : flags;

  // Live commit value, also the forwarding source
  assign fwd.write = executed && writes_rd(ex_ctrl.op);
  assign fwd.rd    = ex_ctrl.rd;
  assign fwd.data  = alu_data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags  <= '0;
      result <= '0;
    end else begin
      flags           <= next_flags;
      result.valid    <= ex_ctrl.valid;
      result.executed <= executed;
      result.write    <= fwd.write;
      result.rd       <= ex_ctrl.rd;
      result.data     <= executed ? alu_data : '0;    // Skipped ops retire zero
      result.flags    <= next_flags;
    end
  end

  a_write_executed: assert property (
    @(posedge clk) disable iff (reset) result.write |-> result.executed
  ) else $error("register write retired from a skipped instruction");

endmodule

//--- hw/dp_core.sv
// Two-stage data-processing core
`timescale 1ns/1ps

module dp_core import dp_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    instr_valid,
  input  word_t   instr,
  output result_t result,
  output flags_t  flags
);

  reg_idx_t rn_idx;
  reg_idx_t rm_idx;
  word_t    rn_data;
  word_t    rm_data;
  ex_ctrl_t ex_ctrl;
  fwd_t     fwd;

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rn_idx  (rn_idx),
    .rm_idx  (rm_idx),
    .wr_idx  (fwd.rd),                          // Write port fed by the commit value
    .wr_en   (fwd.write),
    .wr_data (fwd.data),
    .rn_data (rn_data),
    .rm_data (rm_data)
  );

  decode_stage u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rn_idx      (rn_idx),
    .rm_idx      (rm_idx),
    .rn_data     (rn_data),
    .rm_data     (rm_data),
    .fwd         (fwd),
    .ex_ctrl     (ex_ctrl)
  );

  execute_stage u_execute (
    .clk     (clk),
    .reset   (reset),
    .ex_ctrl (ex_ctrl),
    .fwd     (fwd),
    .result  (result),
    .flags   (flags)
  );

endmodule

//--- test/dp_checker.sv
// Data-processing core checker
`timescale 1ns/1ps

module dp_checker import dp_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    instr_valid,
  input word_t   instr,
  input result_t result,
  input flags_t  flags
);

  typedef struct packed {
    result_t     exp;
    logic [31:0] due;                           // Edge that registers the result
  } pending_t;

  pending_t    expect_q[$];
  word_t       shadow_regs [NUM_REGS];
  flags_t      shadow_flags;
  logic [31:0] edge_count;
  string       test_name = "none";
  int          test_errors = 0;
  int          passed_count = 0;
  int          failed_count = 0;

  function automatic word_t ror_word(word_t v, int amt);
    word_t r;
    r = v;
    for (int i = 0; i < amt; i++) begin
      r = {r[0], r[WORD_W-1:1]};
    end
    return r;
  endfunction

  function automatic word_t asr_word(word_t v, int amt);
    word_t r;
    r = v;
    for (int i = 0; i < amt; i++) begin
      r = {r[WORD_W-1], r[WORD_W-1:1]};
    end
    return r;
  endfunction

  // Odd codes invert the test of the even code below them
  function automatic logic cond_holds(logic [3:0] cond, flags_t f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c && !f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = !f.z && (f.n == f.v);
      default: base = 1'b1;                     // AL, and NV as its inverse
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic word_t second_operand(word_t ins);
    word_t rm;
    int    amt;
    rm  = shadow_regs[ins[3:0]];
    amt = int'(ins[11:7]);
    if (ins[25]) begin
      return ror_word({24'h0, ins[7:0]}, 2 * int'(ins[11:8]));
    end
    if (amt == 0) begin
      return rm;                                // Zero amount is no shift
    end
    case (ins[6:5])
      2'b00:   return rm << amt;
      2'b01:   return rm >> amt;
      2'b10:   return asr_word(rm, amt);
      default: return ror_word(rm, amt);
    endcase
  endfunction

  // Reference result of one instruction over the shadow state
  function automatic result_t model_instr(word_t ins, flags_t f);
    result_t     r;
    alu_op_t     op;
    word_t       a;
    word_t       b;
    word_t       x;
    word_t       y;
    word_t       k;
    word_t       d;
    logic [32:0] wide;
    longint      sres;
    logic        arith;
    logic        sub;
    logic        executed;
    flags_t      nf;
    op    = alu_op_t'(ins[24:21]);
    a     = shadow_regs[ins[19:16]];
    b     = second_operand(ins);
    x     = a;
    y     = b;
    k     = '0;
    arith = 1'b1;
    sub   = 1'b0;
    case (op)
      OP_ADC:         k = {31'h0, f.c};
      OP_SUB, OP_CMP: sub = 1'b1;
      OP_SBC: begin
        sub = 1'b1;
        k   = {31'h0, !f.c};                    // Borrow in
      end
      OP_RSB: begin
        sub = 1'b1;
        x   = b;
        y   = a;
      end
      OP_RSC: begin
        sub = 1'b1;
        x   = b;
        y   = a;
        k   = {31'h0, !f.c};
      end
      OP_ADD, OP_CMN: begin
      end
      default:        arith = 1'b0;
    endcase
    nf = f;
    if (arith) begin
      if (sub) begin
        d    = x - y - k;
        nf.c = ({1'b0, x} >= ({1'b0, y} + {1'b0, k}));    // No borrow
        sres = longint'($signed(x)) - longint'($signed(y)) - longint'(k);
      end else begin
        wide = {1'b0, x} + {1'b0, y} + {1'b0, k};
        d    = wide[31:0];
        nf.c = wide[32];
        sres = longint'($signed(x)) + longint'($signed(y)) + longint'(k);
      end
      nf.v = (sres != longint'($signed(d)));    // True sum does not fit
    end else begin
      case (op)
        OP_AND, OP_TST: d = a & b;
        OP_EOR, OP_TEQ: d = a ^ b;
        OP_ORR:         d = a | b;
        OP_MOV:         d = b;
        OP_BIC:         d = a & ~b;
        default:        d = ~b;
      endcase
    end
    nf.n       = d[31];
    nf.z       = (d == '0);
    executed   = cond_holds(ins[31:28], f);
    r.valid    = 1'b1;
    r.executed = executed;
    r.write    = executed && writes_rd(op);
    r.rd       = ins[15:12];
    r.data     = d;
    r.flags    = (executed && ins[20]) ? nf : f;
    return r;
  endfunction

  task automatic check_field(input string field, input logic [31:0] expv,
                             input logic [31:0] actv);
    if (expv !== actv) begin
      $display("MISMATCH %s %s: expected %h actual %h", test_name, field, expv, actv);
      test_errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic compare_result(input pending_t p);
    if (p.due != edge_count) begin
      report_error($sformatf("result due at edge %0d came at edge %0d", p.due, edge_count));
    end
    check_field("executed", 32'(p.exp.executed), 32'(result.executed));
    check_field("write", 32'(p.exp.write), 32'(result.write));
    check_field("rd", 32'(p.exp.rd), 32'(result.rd));
    if (p.exp.executed) begin
      check_field("data", p.exp.data, result.data);
    end
    check_field("result flags", 32'(p.exp.flags), 32'(result.flags));
    check_field("flags port", 32'(p.exp.flags), 32'(flags));
  endtask

  // Accept side, predicts in program order
  always @(posedge clk) begin : accept
    result_t  e;
    pending_t p;
    if (reset) begin
      edge_count   = '0;
      shadow_flags = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        shadow_regs[i] = '0;
      end
      expect_q.delete();
    end else begin
      edge_count = edge_count + 1;
      if (instr_valid) begin
        e = model_instr(instr, shadow_flags);
        if (e.write) begin
          shadow_regs[e.rd] = e.data;
        end
        shadow_flags = e.flags;
        p.exp        = e;
        p.due        = edge_count + 2;
        expect_q.push_back(p);
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    pending_t p;
    if (!reset) begin
      if (expect_q.size() > 0 && expect_q[0].due < edge_count) begin
        p = expect_q.pop_front();
        report_error($sformatf("instruction accepted at edge %0d was never answered",
                               p.due - 2));
      end
      if (result.valid) begin
        if (expect_q.size() == 0) begin
          report_error("a result appeared with no instruction outstanding");
        end else begin
          p = expect_q.pop_front();
          compare_result(p);
        end
      end
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      passed_count++;
      $display("PASS %s", test_name);
    end else begin
      failed_count++;
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d passed, %0d failed", passed_count, failed_count);
  endtask

  function automatic int outstanding();
    return expect_q.size();
  endfunction

  function automatic int failures();
    return failed_count;
  endfunction

endmodule

//--- test/dp_core_tb.sv
// Data-processing core testbench
`timescale 1ns/1ps

module dp_core_tb import dp_pkg::*; ();

  // Upper bounds per test including drain cycles
  localparam int RESET_CYCLES  = 6;
  localparam int MOV_CYCLES    = 32 + 6;
  localparam int ARITH_CYCLES  = 5 + 96 + 8 + 6;
  localparam int FWD_CYCLES    = 16 + 24 + 6;
  localparam int COND_CYCLES   = 5 + 160 + 6;
  localparam int SHIFT_CYCLES  = 8 + 512 + 6;
  localparam int RANDOM_CYCLES = 64 + 300 * 3 + 6;
  localparam int STIM_CYCLES   = RESET_CYCLES + MOV_CYCLES + ARITH_CYCLES + FWD_CYCLES +
                                 COND_CYCLES + SHIFT_CYCLES + RANDOM_CYCLES;

  logic    clk = 1'b0;
  logic    reset = 1'b1;
  logic    instr_valid = 1'b0;
  word_t   instr = '0;
  result_t result;
  flags_t  flags;

  always #2 clk = ~clk;

  dp_core u_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result      (result),
    .flags       (flags)
  );

  dp_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result      (result),
    .flags       (flags)
  );

  function automatic word_t encode_dp(cond_t cond, logic imm, alu_op_t op, logic s,
                                      reg_idx_t rn, reg_idx_t rd, logic [11:0] op2);
    return {cond, 2'b00, imm, op, s, rn, rd, op2};
  endfunction

  function automatic logic [11:0] imm_operand(logic [3:0] rot, logic [7:0] imm8);
    return {rot, imm8};
  endfunction

  function automatic logic [11:0] shifted_reg(logic [4:0] amt, logic [1:0] kind,
                                              reg_idx_t rm);
    return {amt, kind, 1'b0, rm};               // Bit 4 low selects an immediate amount
  endfunction

  task automatic issue(input word_t ins);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = ins;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    instr       = '0;
  endtask

  task automatic idle_random(input int unsigned max_gap);
    int unsigned gap;
    gap = $urandom_range(max_gap, 0);
    repeat (gap) idle();
  endtask

  // Each ORR adds the next byte to the previous write
  task automatic load_reg(input reg_idx_t rd, input word_t value);
    issue(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, rd, imm_operand(4'd0, value[7:0])));
    issue(encode_dp(COND_AL, 1'b1, OP_ORR, 1'b0, rd, rd, imm_operand(4'd12, value[15:8])));
    issue(encode_dp(COND_AL, 1'b1, OP_ORR, 1'b0, rd, rd, imm_operand(4'd8, value[23:16])));
    issue(encode_dp(COND_AL, 1'b1, OP_ORR, 1'b0, rd, rd, imm_operand(4'd4, value[31:24])));
  endtask

  // r1 zero, r2 most negative, r3 all ones, r4 one, r5 most positive
  task automatic load_corners();
    issue(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd1, imm_operand(4'd0, 8'd0)));
    issue(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd2, imm_operand(4'd1, 8'd2)));
    issue(encode_dp(COND_AL, 1'b1, OP_MVN, 1'b0, 4'd0, 4'd3, imm_operand(4'd0, 8'd0)));
    issue(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd4, imm_operand(4'd0, 8'd1)));
    issue(encode_dp(COND_AL, 1'b1, OP_MVN, 1'b0, 4'd0, 4'd5, imm_operand(4'd1, 8'd2)));
  endtask

  task automatic drain_and_report();
    idle();
    while (u_checker.outstanding() != 0) begin
      idle();
    end
    u_checker.finish_test();
  endtask

  task automatic mov_immediate();
    logic [7:0] imm8;
    u_checker.start_test("mov_immediate");
    for (int rot = 0; rot < 16; rot++) begin
      imm8 = 8'($urandom);
      issue(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'(rot),
                      imm_operand(4'(rot), imm8)));
      issue(encode_dp(COND_AL, 1'b1, OP_MVN, 1'b1, 4'd0, 4'(15 - rot),
                      imm_operand(4'(rot), imm8)));
    end
    drain_and_report();
  endtask

  task automatic arith_flags();
    alu_op_t  ops [8] = '{OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_RSB, OP_RSC, OP_CMP, OP_CMN};
    reg_idx_t rn_list [4] = '{4'd1, 4'd2, 4'd3, 4'd5};
    reg_idx_t rm_list [3] = '{4'd2, 4'd3, 4'd4};
    u_checker.start_test("arith_flags");
    load_corners();
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 4; j++) begin
        for (int m = 0; m < 3; m++) begin
          issue(encode_dp(COND_AL, 1'b0, ops[i], 1'b1, rn_list[j], 4'd6,
                          shifted_reg(5'd0, 2'b00, rm_list[m])));
        end
      end
    end
    for (int i = 0; i < 8; i++) begin
      issue(encode_dp(COND_AL, 1'b0, ops[i], 1'b0, 4'd3, 4'd6,    // S clear
                      shifted_reg(5'd0, 2'b00, 4'd4)));
    end
    drain_and_report();
  endtask

  task automatic back_to_back_forwarding();
    alu_op_t  chain_ops [8] = '{OP_ADD, OP_SUB, OP_EOR, OP_ORR, OP_RSB, OP_ADC, OP_BIC,
                                OP_ADD};
    reg_idx_t prev;
    reg_idx_t prev2;
    reg_idx_t dst;
    u_checker.start_test("back_to_back_forwarding");
    for (int pass = 0; pass < 2; pass++) begin
      load_reg(4'd7, $urandom);
      load_reg(4'd8, $urandom);
      prev2 = 4'd7;
      prev  = 4'd8;
      for (int i = 0; i < 8; i++) begin
        dst = 4'(7 + (i % 3));
        issue(encode_dp(COND_AL, 1'b0, chain_ops[i], 1'b1, prev, dst,
                        shifted_reg(5'(i * 3), 2'(i), prev2)));
        prev2 = prev;
        prev  = dst;
        if (pass == 1) begin
          idle();                               // Value now comes from the register file
        end
      end
    end
    drain_and_report();
  endtask

  task automatic conditional_execution();
    reg_idx_t lhs [5] = '{4'd4, 4'd1, 4'd2, 4'd5, 4'd4};
    reg_idx_t rhs [5] = '{4'd4, 4'd4, 4'd4, 4'd3, 4'd1};
    u_checker.start_test("conditional_execution");
    load_corners();
    for (int s = 0; s < 5; s++) begin
      for (int c = 0; c < 16; c++) begin
        issue(encode_dp(COND_AL, 1'b0, OP_CMP, 1'b1, lhs[s], 4'd0,
                        shifted_reg(5'd0, 2'b00, rhs[s])));
        issue(encode_dp(cond_t'(4'(c)), 1'b0, OP_ADD, 1'b1, 4'd10, 4'd10,
                        shifted_reg(5'd0, 2'b00, 4'd4)));
      end
    end
    drain_and_report();
  endtask

  task automatic shifted_operands();
    alu_op_t logic_ops [4] = '{OP_ORR, OP_EOR, OP_AND, OP_BIC};
    u_checker.start_test("shifted_operands");
    load_reg(4'd11, $urandom);
    load_reg(4'd13, $urandom | 32'h8000_0000);  // Negative Rm separates ASR from LSR
    for (int i = 0; i < 4; i++) begin
      for (int t = 0; t < 4; t++) begin
        for (int a = 0; a < 32; a++) begin
          issue(encode_dp(COND_AL, 1'b0, logic_ops[i], 1'(a), 4'd11, 4'd12,
                          shifted_reg(5'(a), 2'(t), 4'd13)));
        end
      end
    end
    drain_and_report();
  endtask

  task automatic random_stream();
    word_t ins;
    u_checker.start_test("random_stream");
    for (int r = 0; r < 16; r++) begin
      load_reg(4'(r), $urandom);
    end
    for (int n = 0; n < 300; n++) begin
      ins        = $urandom;
      ins[27:26] = 2'b00;                       // Data-processing class
      if (!ins[25]) begin
        ins[4] = 1'b0;
      end
      issue(ins);
      idle_random(2);
    end
    drain_and_report();
  endtask

  initial begin
    void'($urandom(45363));
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    mov_immediate();
    arith_flags();
    back_to_back_forwarding();
    conditional_execution();
    shifted_operands();
    random_stream();
    u_checker.print_summary();
    if (u_checker.failures() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(STIM_CYCLES * 4 + 200);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

//--- dp_core.f
hw/dp_pkg.sv
hw/reg_file.sv
hw/operand_shifter.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/dp_core.sv
test/dp_checker.sv
test/dp_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the data-processing core simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dp_core_sim
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -f dp_core.f --top-module dp_core_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1; then
  cat "$LOG_FILE"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG_FILE"

if grep -qx "all tests passed" "$LOG_FILE"; then
  exit 0
fi
exit 1
